// File: src.f
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/pipe_reg.sv
verilog/exec_unit.sv
verilog/core_top.sv
tests/core_assertions.sv
tests/core_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f src.f --top-module core_tb -Mdir obj_dir -o core_sim
	./obj_dir/core_sim 2>&1 | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/core_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module core_tb;

    localparam int NUM_INSTR  = 2000;
    localparam int CLK_PERIOD = 10;
    localparam int TIMEOUT_NS = (NUM_INSTR + 100) * CLK_PERIOD + 500;

    // one expected snapshot of the DUT outputs
    typedef struct packed {
        logic                wb_en;
        logic [`REG_W-1:0]   wb_idx;
        logic [`DATA_W-1:0]  wb_data;
        logic                io_valid;
        logic [`DATA_W-1:0]  io_data;
        cpu_isa_pkg::flags_t flags;
        logic                exact;     // wb_idx and wb_data must be zero on a bubble
    } expect_t;

    logic                clk;
    logic                rst;
    logic [`DATA_W-1:0]  instr;
    logic [`DATA_W-1:0]  imm;
    logic                instr_valid;
    logic                flush;
    logic                wb_en;
    logic [`REG_W-1:0]   wb_idx;
    logic [`DATA_W-1:0]  wb_data;
    logic                io_valid;
    logic [`DATA_W-1:0]  io_data;
    cpu_isa_pkg::flags_t flags;

    // architectural state of the reference model
    logic [`DATA_W-1:0]  model_regs [`REG_CNT];
    cpu_isa_pkg::flags_t model_flags;
    logic [`DATA_W-1:0]  model_io;      // io_data holds the last OUT value
    expect_t             exp_q [$];

    core_top u_core_top (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .imm         (imm),
        .instr_valid (instr_valid),
        .flush       (flush),
        .wb_en       (wb_en),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data),
        .io_valid    (io_valid),
        .io_data     (io_data),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [7:0] exp_v,
                                   input logic [7:0] act_v);
        $display("** Error at %0t: %s expected %02h, got %02h", $time, name, exp_v, act_v);
        $display("TEST RESULT: FAIL");
        $fatal(1, "output mismatch on %s", name);
    endtask

    // executes one presented instruction in program order
    task automatic run_model(input logic [7:0] ins, input logic [7:0] im,
                             input logic valid, input logic fl, output expect_t e);
        logic [3:0] op;
        logic [1:0] a;
        logic [1:0] b;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] res;
        logic       c;
        logic       wr;
        logic       fu;
        op  = ins[7:4];
        a   = ins[3:2];
        b   = ins[1:0];
        x   = model_regs[a];
        y   = model_regs[b];
        res = 8'h00;
        c   = 1'b0;
        wr  = 1'b0;
        fu  = 1'b0;
        e   = '0;
        if (!valid || fl) begin
            e.exact = 1'b1;
        end else begin
            case (op)
                cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_ADDI: begin
                    res = x + ((op == cpu_isa_pkg::OP_ADDI) ? im : y);
                    c   = (res < x);        // carry out when the sum wraps
                    wr  = 1'b1;
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_SUB, cpu_isa_pkg::OP_CMP: begin
                    res = x - y;
                    c   = (x < y);          // borrow
                    wr  = (op == cpu_isa_pkg::OP_SUB);
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_AND: begin
                    res = x & y;
                    wr  = 1'b1;
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_OR: begin
                    res = x | y;
                    wr  = 1'b1;
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_XOR: begin
                    res = x ^ y;
                    wr  = 1'b1;
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_LDI: begin
                    res = im;
                    wr  = 1'b1;
                end
                cpu_isa_pkg::OP_NOT: begin
                    res = ~y;
                    wr  = 1'b1;
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_SHL: begin
                    res = {y[6:0], 1'b0};
                    c   = y[7];
                    wr  = 1'b1;
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_SHR: begin
                    res = {1'b0, y[7:1]};
                    c   = y[0];
                    wr  = 1'b1;
                    fu  = 1'b1;
                end
                cpu_isa_pkg::OP_MOV: begin
                    res = y;
                    wr  = 1'b1;
                end
                cpu_isa_pkg::OP_OUT: begin
                    e.io_valid = 1'b1;
                    model_io   = y;
                end
                default: ;  // NOP and the two unused codes
            endcase
            if (wr) begin
                model_regs[a] = res;
                e.wb_en       = 1'b1;
                e.wb_idx      = a;
                e.wb_data     = res;
            end
            if (fu) begin
                model_flags.z = (res == 8'h00);
                model_flags.n = res[7];
                model_flags.c = c;
            end
        end
        e.io_data = model_io;
        e.flags   = model_flags;
    endtask

    task automatic check_outputs(input expect_t e);
        assert (wb_en == e.wb_en) else report_mismatch("wb_en", {7'b0, e.wb_en}, {7'b0, wb_en});
        if (e.wb_en || e.exact) begin
            assert (wb_idx == e.wb_idx)
                else report_mismatch("wb_idx", {6'b0, e.wb_idx}, {6'b0, wb_idx});
            assert (wb_data == e.wb_data) else report_mismatch("wb_data", e.wb_data, wb_data);
        end
        assert (io_valid == e.io_valid)
            else report_mismatch("io_valid", {7'b0, e.io_valid}, {7'b0, io_valid});
        assert (io_data == e.io_data) else report_mismatch("io_data", e.io_data, io_data);
        assert (flags == e.flags) else report_mismatch("flags", {5'b0, e.flags}, {5'b0, flags});
    endtask

    initial begin
        expect_t     e;
        logic [31:0] r;
        void'($urandom(32'h6f7e));
        rst         = 1'b0;
        instr       = '0;
        imm         = '0;
        instr_valid = 1'b0;
        flush       = 1'b0;
        model_flags = '0;
        model_io    = '0;
        for (int i = 0; i < `REG_CNT; i++) begin
            model_regs[i] = '0;
        end
        // the first two samples after release still show the reset state
        e       = '0;
        e.exact = 1'b1;
        exp_q.push_back(e);
        exp_q.push_back(e);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int n = 0; n < NUM_INSTR + 2; n++) begin
            if (exp_q.size() == 2) begin
                check_outputs(exp_q.pop_front());   // presented two cycles ago
            end
            r = $urandom;
            if (n < NUM_INSTR) begin
                instr       = r[7:0];
                imm         = r[15:8];
                instr_valid = (($urandom % 100) < 90);
                flush       = (($urandom % 100) < 5);
            end else begin
                instr_valid = 1'b0;     // drain
                flush       = 1'b0;
            end
            run_model(instr, imm, instr_valid, flush, e);
            exp_q.push_back(e);
            @(negedge clk);
            assert (u_core_top.u_core_assertions.fail_cnt == 0) else begin
                $display("** Error at %0t: a bound assertion on the pipeline failed", $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "bound assertion failure");
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("** Error at %0t: watchdog expired before the stimulus finished", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation timeout");
    end

endmodule

// File: tests/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 flush,
    input logic                 wb_en,
    input logic                 io_valid,
    input cpu_pipe_pkg::id_ex_t id_ex_q
);

    int unsigned fail_cnt = 0;      // number of failed properties

    // nothing can reach writeback right after reset
    wb_quiet_after_reset: assert property (@(posedge clk) $rose(rst) |-> !wb_en)
        else begin
            $error("wb_en set in the first cycle after reset release");
            fail_cnt++;
        end

    // flushed slot turns into a bubble
    flush_clears_id_ex: assert property (
        @(posedge clk) disable iff (!rst) flush |=> (id_ex_q == '0)
    ) else begin
        $error("ID/EX payload not zero after flush");
        fail_cnt++;
    end

    // OUT never writes a register
    io_without_write: assert property (
        @(posedge clk) disable iff (!rst) io_valid |-> !wb_en
    ) else begin
        $error("io_valid and wb_en high together");
        fail_cnt++;
    end

endmodule

bind core_top core_assertions u_core_assertions (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .wb_en    (wb_en),
    .io_valid (io_valid),
    .id_ex_q  (id_ex_q)
);

// File: verilog/core_top.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module core_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [`DATA_W-1:0]  instr,
    input  logic [`DATA_W-1:0]  imm,
    input  logic                instr_valid,
    input  logic                flush,
    output logic                wb_en,
    output logic [`REG_W-1:0]   wb_idx,
    output logic [`DATA_W-1:0]  wb_data,
    output logic                io_valid,
    output logic [`DATA_W-1:0]  io_data,
    output cpu_isa_pkg::flags_t flags
);

    logic [`REG_W-1:0]    ra_idx;
    logic [`REG_W-1:0]    rb_idx;
    logic [`DATA_W-1:0]   ra_val;
    logic [`DATA_W-1:0]   rb_val;
    cpu_pipe_pkg::id_ex_t id_ex_d;
    cpu_pipe_pkg::id_ex_t id_ex_q;
    cpu_pipe_pkg::ex_wb_t ex_wb_d;
    cpu_pipe_pkg::ex_wb_t ex_wb_q;

    decode_unit u_decode (
        .instr       (instr),
        .imm         (imm),
        .instr_valid (instr_valid),
        .ra_val      (ra_val),
        .rb_val      (rb_val),
        .ra          (ra_idx),
        .rb          (rb_idx),
        .id_ex       (id_ex_d)
    );

    // written from the EX/WB stage output
    reg_file u_rf (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_a  (ra_idx),
        .rd_idx_b  (rb_idx),
        .wr_en     (ex_wb_q.reg_write),
        .wr_idx    (ex_wb_q.dest_idx),
        .wr_data   (ex_wb_q.result),
        .rd_data_a (ra_val),
        .rd_data_b (rb_val)
    );

    pipe_reg #(.payload_t(cpu_pipe_pkg::id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    exec_unit u_exec (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex_q),
        .ex_wb_q  (ex_wb_q),
        .ex_wb_d  (ex_wb_d),
        .flags    (flags),
        .io_valid (io_valid),
        .io_data  (io_data)
    );

    pipe_reg #(.payload_t(cpu_pipe_pkg::ex_wb_t)) u_ex_wb (
        .clk   (clk),
        .rst   (rst),
        .flush (1'b0),      // EX always completes
        .d     (ex_wb_d),
        .q     (ex_wb_q)
    );

    assign wb_en   = ex_wb_q.reg_write;
    assign wb_idx  = ex_wb_q.dest_idx;
    assign wb_data = ex_wb_q.result;

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module exec_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pipe_pkg::id_ex_t id_ex,
    input  cpu_pipe_pkg::ex_wb_t ex_wb_q,
    output cpu_pipe_pkg::ex_wb_t ex_wb_d,
    output cpu_isa_pkg::flags_t  flags,
    output logic                 io_valid,
    output logic [`DATA_W-1:0]   io_data
);

    logic [`DATA_W-1:0] op_a;       // R[ra] after forwarding
    logic [`DATA_W-1:0] rb_fwd;     // R[rb] after forwarding
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] result;
    logic               carry;
    logic [`DATA_W:0]   wide;       // top bit is carry or borrow
    logic               hit_a;
    logic               hit_b;
    cpu_isa_pkg::flags_t flags_next;

    // EX/WB holds the instruction just ahead, which the register file
    // has not seen yet
    assign hit_a  = ex_wb_q.reg_write && (ex_wb_q.dest_idx == id_ex.ra);
    assign hit_b  = ex_wb_q.reg_write && (ex_wb_q.dest_idx == id_ex.rb);
    assign op_a   = hit_a ? ex_wb_q.result : id_ex.ra_val;
    assign rb_fwd = hit_b ? ex_wb_q.result : id_ex.rb_val;
    assign op_b   = (id_ex.alu_src == cpu_isa_pkg::SRC_IMM) ? id_ex.imm : rb_fwd;

    always_comb begin
        wide   = '0;
        result = '0;
        carry  = 1'b0;
        case (id_ex.alu_op)
            cpu_isa_pkg::ALU_ADD: begin
                wide   = {1'b0, op_a} + {1'b0, op_b};
                result = wide[`DATA_W-1:0];
                carry  = wide[`DATA_W];
            end
            cpu_isa_pkg::ALU_SUB: begin
                wide   = {1'b0, op_a} - {1'b0, op_b};
                result = wide[`DATA_W-1:0];
                carry  = wide[`DATA_W];     // set when op_a < op_b
            end
            cpu_isa_pkg::ALU_AND: result = op_a & op_b;
            cpu_isa_pkg::ALU_OR:  result = op_a | op_b;
            cpu_isa_pkg::ALU_XOR: result = op_a ^ op_b;
            cpu_isa_pkg::ALU_NOT: result = ~op_b;
            cpu_isa_pkg::ALU_SHL: begin
                result = op_b << 1;
                carry  = op_b[`DATA_W-1];
            end
            cpu_isa_pkg::ALU_SHR: begin
                result = op_b >> 1;
                carry  = op_b[0];
            end
            cpu_isa_pkg::ALU_PASS_B: result = op_b;
            default: ;
        endcase
    end

    assign flags_next = '{z: (result == '0), n: result[`DATA_W-1], c: carry};

    assign ex_wb_d = '{reg_write: id_ex.reg_write,
                       dest_idx:  id_ex.dest_idx,
                       result:    result};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flags <= '0;
        end else if (id_ex.update_flags) begin
            flags <= flags_next;
        end
    end

    // OUT strobe lines up with the EX/WB stage
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            io_valid <= 1'b0;
            io_data  <= '0;
        end else begin
            io_valid <= id_ex.io_write;
            if (id_ex.io_write) begin
                io_data <= rb_fwd;  // last OUT value holds
            end
        end
    end

endmodule

// File: verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // zero payload doubles as the bubble
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;    // drop the stage contents
        end else begin
            q <= d;
        end
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [`REG_W-1:0]   rd_idx_a,
    input  logic [`REG_W-1:0]   rd_idx_b,
    input  logic                wr_en,
    input  logic [`REG_W-1:0]   wr_idx,
    input  logic [`DATA_W-1:0]  wr_data,
    output logic [`DATA_W-1:0]  rd_data_a,
    output logic [`DATA_W-1:0]  rd_data_b
);

    logic [`DATA_W-1:0] regs [`REG_CNT];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through covers an instruction two steps behind its producer
    assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
    assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

// File: verilog/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_unit (
    input  logic [`DATA_W-1:0]  instr,
    input  logic [`DATA_W-1:0]  imm,
    input  logic                instr_valid,
    input  logic [`DATA_W-1:0]  ra_val,
    input  logic [`DATA_W-1:0]  rb_val,
    output logic [`REG_W-1:0]   ra,
    output logic [`REG_W-1:0]   rb,
    output cpu_pipe_pkg::id_ex_t id_ex
);

    cpu_isa_pkg::opcode_e opcode;

    assign opcode = cpu_isa_pkg::opcode_e'(instr[7:4]);
    assign ra     = instr[3:2];     // register file read indices
    assign rb     = instr[1:0];

    always_comb begin
        id_ex = '0;
        if (instr_valid) begin
            id_ex.ra       = ra;
            id_ex.rb       = rb;
            id_ex.ra_val   = ra_val;
            id_ex.rb_val   = rb_val;
            id_ex.imm      = imm;
            id_ex.dest_idx = ra;    // every writing opcode targets ra

            case (opcode)
                cpu_isa_pkg::OP_ADD: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_ADD;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_SUB: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_SUB;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_AND: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_AND;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_OR: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_OR;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_XOR: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_XOR;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_ADDI: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_ADD;
                    id_ex.alu_src      = cpu_isa_pkg::SRC_IMM;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_LDI: begin
                    id_ex.alu_op    = cpu_isa_pkg::ALU_PASS_B;
                    id_ex.alu_src   = cpu_isa_pkg::SRC_IMM;
                    id_ex.reg_write = 1'b1;
                end
                // unary ops work on rb and land in ra
                cpu_isa_pkg::OP_NOT: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_NOT;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_SHL: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_SHL;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_SHR: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_SHR;
                    id_ex.reg_write    = 1'b1;
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_MOV: begin
                    id_ex.alu_op    = cpu_isa_pkg::ALU_PASS_B;
                    id_ex.reg_write = 1'b1;
                end
                cpu_isa_pkg::OP_CMP: begin
                    id_ex.alu_op       = cpu_isa_pkg::ALU_SUB;  // flags only
                    id_ex.update_flags = 1'b1;
                end
                cpu_isa_pkg::OP_OUT: id_ex.io_write = 1'b1;
                default: ;  // NOP and unused codes leave control at zero
            endcase
        end
    end

endmodule

// File: verilog/cpu_pipe_pkg.sv
`include "cpu_consts.svh"

package cpu_pipe_pkg;

    // everything EX needs from decode
    // an all-zero value is a NOP since every control bit is clear
    typedef struct packed {
        cpu_isa_pkg::alu_op_e   alu_op;
        cpu_isa_pkg::alu_src_e  alu_src;
        logic                   reg_write;
        logic                   update_flags;
        logic                   io_write;       // OUT strobe
        logic [`REG_W-1:0]      dest_idx;
        logic [`REG_W-1:0]      ra;             // kept for forwarding compares
        logic [`REG_W-1:0]      rb;
        logic [`DATA_W-1:0]     ra_val;
        logic [`DATA_W-1:0]     rb_val;
        logic [`DATA_W-1:0]     imm;
    } id_ex_t;

    // result on its way back to the register file
    typedef struct packed {
        logic                   reg_write;
        logic [`REG_W-1:0]      dest_idx;
        logic [`DATA_W-1:0]     result;
    } ex_wb_t;

endpackage

// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // instruction class, taken from instr[7:4]
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LDI  = 4'd7,
        OP_NOT  = 4'd8,
        OP_SHL  = 4'd9,
        OP_SHR  = 4'd10,
        OP_MOV  = 4'd11,
        OP_CMP  = 4'd12,
        OP_OUT  = 4'd13     // 14 and 15 decode as NOP
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NOP    = 4'd0,
        ALU_ADD    = 4'd1,
        ALU_SUB    = 4'd2,  // also used by CMP
        ALU_AND    = 4'd3,
        ALU_OR     = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_NOT    = 4'd6,
        ALU_SHL    = 4'd7,
        ALU_SHR    = 4'd8,
        ALU_PASS_B = 4'd9   // MOV and LDI
    } alu_op_e;

    // second ALU operand
    typedef enum logic {
        SRC_REG = 1'b0,
        SRC_IMM = 1'b1
    } alu_src_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } flags_t;

endpackage

// File: verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// width of a register, an immediate and the ALU
`define DATA_W 8

// general registers R0..R3
`define REG_CNT 4

// index width that covers REG_CNT
`define REG_W 2

// instruction word fields
// [7:4] opcode
// [3:2] ra which is also the destination
// [1:0] rb

`endif
